//--- vlog.f
src/slc3Pkg.sv
src/regFile.sv
src/datapath.sv
src/controlUnit.sv
src/wordMemory.sv
src/slc3Top.sv
test/clockGen.sv
test/slc3Tb.sv

//--- test/slc3Tb.sv
`timescale 1ns/1ps

module slc3Tb;

	localparam int MEM_AW = 8;
	localparam int DEPTH = 2 ** MEM_AW;
	localparam int TIMEOUT = 5000;
	// Base register value for the 0xA0 to 0xDF data window
	localparam logic [15:0] DATA_BASE = 16'h00c0;

	logic Clk, rstN, run, cont, progWe, halted, paused;
	logic [MEM_AW-1:0] progAddr;
	logic [15:0] progWdata, progRdata, pc, ir;
	logic [11:0] LED;

	logic [31:0] lfsr;
	logic [15:0] prog [$];
	logic [15:0] imgMem [DEPTH];
	// Reference machine state kept across programs like the DUT registers
	logic [15:0] modelMem [DEPTH];
	logic [15:0] modelReg [8];
	logic [2:0] modelCc;
	logic [11:0] pauseQ [$];
	// PC just past each PAUSE
	logic [15:0] pausePcQ [$];
	logic [11:0] expLed;

	clockGen clk0 (.Clk(Clk), .rstN(rstN));

	slc3Top #(.MEM_AW(MEM_AW)) dut0 (
		.Clk(Clk), .rstN(rstN), .run(run), .cont(cont),
		.progWe(progWe), .progAddr(progAddr), .progWdata(progWdata),
		.progRdata(progRdata), .LED(LED), .pc(pc), .ir(ir),
		.halted(halted), .paused(paused)
	);

	task automatic failRun();
		$display("=== FAIL ===");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkWord(input string name, input logic [15:0] got, input logic [15:0] exp);
		assert (got === exp) else begin
			$display("mismatch %s: got %h, expected %h", name, got, exp);
			failRun();
		end
	endtask

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic lfsrBit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [15:0] randBits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[14:0], lfsrBit()};
		end
		return v;
	endfunction

	// Instruction encoders
	function automatic logic [15:0] aluReg(input logic [3:0] op, input logic [2:0] dr,
			input logic [2:0] sr1, input logic [2:0] sr2);
		return {op, dr, sr1, 3'b000, sr2};
	endfunction

	function automatic logic [15:0] aluImm(input logic [3:0] op, input logic [2:0] dr,
			input logic [2:0] sr1, input logic [4:0] imm);
		return {op, dr, sr1, 1'b1, imm};
	endfunction

	function automatic logic [15:0] memInst(input logic [3:0] op, input logic [2:0] r,
			input logic [2:0] base, input logic [5:0] off);
		return {op, r, base, off};
	endfunction

	function automatic logic [15:0] pauseInst(input logic [11:0] v);
		return {slc3Pkg::opPause, v};
	endfunction

	function automatic void emit(input logic [15:0] w);
		prog.push_back(w);
	endfunction

	// Memory fill where every address bit changes the word
	function automatic void startProgram();
		for (int a = 0; a < DEPTH; a++) begin
			imgMem[a] = 16'(a * 40503) ^ 16'h3c3c;
		end
		prog.delete();
		// R7 = 0, R6 = DATA_BASE from the word skipped by BRnzp
		emit(aluImm(slc3Pkg::opAnd, 3'd7, 3'd7, 5'd0));
		emit(memInst(slc3Pkg::opLdr, 3'd6, 3'd7, 6'd3));
		emit({slc3Pkg::opBr, 3'b111, 9'd1});
		emit(DATA_BASE);
	endfunction

	function automatic void emitRandomAlu(input logic [2:0] dr, input logic [2:0] sr1);
		logic [1:0] kind;
		logic [3:0] op;
		kind = 2'(randBits(2));
		op = (kind == 2'd1) ? slc3Pkg::opAnd : slc3Pkg::opAdd;
		if (kind == 2'd2) begin
			emit({slc3Pkg::opNot, dr, sr1, 6'h3f});
		end else if (randBits(1) == 16'd1) begin
			emit(aluImm(op, dr, sr1, 5'(randBits(5))));
		end else begin
			emit(aluReg(op, dr, sr1, 3'(randBits(3))));
		end
	endfunction

	function automatic void setReg(input logic [2:0] dr, input logic [15:0] v);
		modelReg[dr] = v;
		modelCc = v[15] ? 3'b100 : ((v == 16'd0) ? 3'b010 : 3'b001);
	endfunction

	// LC-3 rules for the supported opcodes up to PAUSE 0xFFF
	function automatic void runModel();
		logic [15:0] inst, b, ea, pcM;
		logic done;
		pauseQ.delete();
		pausePcQ.delete();
		pcM = '0;
		done = 1'b0;
		for (int steps = 0; steps < 4000 && !done; steps++) begin
			inst = modelMem[pcM[MEM_AW-1:0]];
			pcM = pcM + 16'd1;
			b = inst[5] ? {{11{inst[4]}}, inst[4:0]} : modelReg[inst[2:0]];
			ea = modelReg[inst[8:6]] + {{10{inst[5]}}, inst[5:0]};
			case (inst[15:12])
				slc3Pkg::opAdd: setReg(inst[11:9], modelReg[inst[8:6]] + b);
				slc3Pkg::opAnd: setReg(inst[11:9], modelReg[inst[8:6]] & b);
				slc3Pkg::opNot: setReg(inst[11:9], ~modelReg[inst[8:6]]);
				slc3Pkg::opBr: begin
					if (|(inst[11:9] & modelCc)) begin
						pcM = pcM + {{7{inst[8]}}, inst[8:0]};
					end
				end
				slc3Pkg::opLdr: setReg(inst[11:9], modelMem[ea[MEM_AW-1:0]]);
				slc3Pkg::opStr: modelMem[ea[MEM_AW-1:0]] = modelReg[inst[11:9]];
				slc3Pkg::opJmp: pcM = modelReg[inst[8:6]];
				slc3Pkg::opPause: begin
					pauseQ.push_back(inst[11:0]);
					pausePcQ.push_back(pcM);
					done = (inst[11:0] == 12'hfff);
				end
				default: done = 1'b1;
			endcase
		end
	endfunction

	task automatic nextCycle();
		@(posedge Clk);
		#1;
	endtask

	task automatic waitStatus(input logic onPaused, input logic level, input string what);
		int n;
		n = 0;
		while (((onPaused ? paused : halted) !== level) && n < TIMEOUT) begin
			nextCycle();
			n++;
		end
		assert ((onPaused ? paused : halted) === level) else begin
			$display("timed out after %0d cycles waiting for %s", TIMEOUT, what);
			failRun();
		end
	endtask

	// Load, run, follow every pause, then read the whole memory back
	task automatic runProgram(input string name);
		logic [15:0] expPc;
		int hold;
		assert (prog.size() <= 'ha0) else begin
			$display("program %s runs into the data window", name);
			failRun();
		end
		foreach (prog[i]) begin
			imgMem[i] = prog[i];
		end
		modelMem = imgMem;
		runModel();
		for (int a = 0; a < DEPTH; a++) begin
			progWe = 1'b1;
			progAddr = MEM_AW'(a);
			progWdata = imgMem[a];
			nextCycle();
		end
		progWe = 1'b0;
		run = 1'b1;
		nextCycle();
		run = 1'b0;
		while (pauseQ.size() > 0) begin
			expLed = pauseQ.pop_front();
			expPc = pausePcQ.pop_front();
			waitStatus(1'b1, 1'b1, $sformatf("pause %h in %s", expLed, name));
			checkWord("pc", pc, expPc);
			// Core must stay put until cont
			hold = int'(randBits(2));
			for (int n = 0; n < hold; n++) begin
				nextCycle();
				checkWord("paused", {15'd0, paused}, 16'd1);
				checkWord("pc", pc, expPc);
			end
			cont = 1'b1;
			nextCycle();
			cont = 1'b0;
			waitStatus(1'b1, 1'b0, "release of pause");
		end
		waitStatus(1'b0, 1'b1, $sformatf("halt after %s", name));
		progAddr = '0;
		for (int a = 0; a < DEPTH; a++) begin
			nextCycle();
			checkWord($sformatf("mem[%0h]", a), progRdata, modelMem[a]);
			progAddr = MEM_AW'(a + 1);
		end
	endtask

	// LED and ir on the falling edge of every paused cycle
	always @(negedge Clk) begin
		if (rstN === 1'b1 && paused === 1'b1) begin
			checkWord("LED", {4'h0, LED}, {4'h0, expLed});
			checkWord("ir", ir, pauseInst(expLed));
		end
	end

	initial begin
		int n;
		logic [2:0] r;
		logic [4:0] imm;
		run = 1'b0;
		cont = 1'b0;
		progWe = 1'b0;
		progAddr = '0;
		progWdata = '0;
		lfsr = 32'hc8fa;
		expLed = '0;
		modelCc = 3'b010;
		for (int i = 0; i < 8; i++) begin
			modelReg[i] = '0;
		end
		n = 0;
		while (rstN !== 1'b1 && n < 20) begin
			@(posedge Clk);
			n++;
		end
		assert (rstN === 1'b1) else begin
			$display("reset was never released");
			failRun();
		end
		#1;
		checkWord("halted", {15'd0, halted}, 16'd1);
		checkWord("paused", {15'd0, paused}, 16'd0);
		checkWord("LED", {4'h0, LED}, 16'd0);
		checkWord("pc", pc, 16'd0);
		checkWord("ir", ir, 16'd0);

		// ALU ops in both forms with each result stored
		startProgram();
		for (int i = 0; i < 6; i++) begin
			emit(memInst(slc3Pkg::opLdr, 3'(i), 3'd6, 6'(randBits(6))));
		end
		for (int i = 0; i < 16; i++) begin
			r = 3'(randBits(3) % 6);
			emitRandomAlu(r, 3'(randBits(3)));
			emit(memInst(slc3Pkg::opStr, r, 3'd6, 6'(i - 32)));
		end
		emit(pauseInst(12'hfff));
		emit(16'hf000);
		runProgram("alu");

		// Load, change, store at random offsets
		startProgram();
		for (int i = 0; i < 12; i++) begin
			r = 3'(randBits(3) % 6);
			emit(memInst(slc3Pkg::opLdr, r, 3'd6, 6'(randBits(6))));
			emitRandomAlu(r, r);
			emit(memInst(slc3Pkg::opStr, r, 3'd6, 6'(randBits(6))));
		end
		emit(pauseInst(12'hfff));
		emit(16'hf000);
		runProgram("load/store");

		// Every nzp mask after negative, zero and positive results
		startProgram();
		emit(aluImm(slc3Pkg::opAnd, 3'd5, 3'd5, 5'd0));
		for (int m = 0; m < 8; m++) begin
			for (int k = 0; k < 3; k++) begin
				imm = (k == 0) ? 5'(-(1 + randBits(4) % 15)) :
				      (k == 1) ? 5'd0 : 5'(1 + randBits(4) % 15);
				emit(aluImm(slc3Pkg::opAnd, 3'd0, 3'd0, 5'd0));
				emit(aluImm(slc3Pkg::opAdd, 3'd0, 3'd0, imm));
				emit({slc3Pkg::opBr, 3'(m), 9'd1});
				// Counter bumps only when the branch falls through
				emit(aluImm(slc3Pkg::opAdd, 3'd5, 3'd5, 5'd1));
				emit(memInst(slc3Pkg::opStr, 3'd5, 3'd6, 6'(m * 3 + k - 32)));
			end
		end
		// Countdown loop adding 3 to R2 until R1 reaches zero
		emit(aluImm(slc3Pkg::opAnd, 3'd1, 3'd1, 5'd0));
		emit(aluImm(slc3Pkg::opAdd, 3'd1, 3'd1, 5'(3 + randBits(3))));
		emit(aluImm(slc3Pkg::opAnd, 3'd2, 3'd2, 5'd0));
		emit(aluImm(slc3Pkg::opAdd, 3'd2, 3'd2, 5'd3));
		emit(aluImm(slc3Pkg::opAdd, 3'd1, 3'd1, 5'h1f));
		emit({slc3Pkg::opBr, 3'b001, 9'h1fd});
		emit(memInst(slc3Pkg::opStr, 3'd2, 3'd6, 6'd0));
		emit(memInst(slc3Pkg::opStr, 3'd1, 3'd6, 6'd1));
		emit(pauseInst(12'hfff));
		emit(16'hf000);
		runProgram("branch");

		// Pauses with random operands followed by a computed jump
		startProgram();
		for (int i = 0; i < 4; i++) begin
			r = 3'(randBits(3) % 6);
			emitRandomAlu(r, 3'(randBits(3)));
			emit(memInst(slc3Pkg::opStr, r, 3'd6, 6'(i)));
			emit(pauseInst(12'(randBits(11))));
		end
		// Data word holds the JMP address
		// Target is three words past the JMP
		imgMem[DATA_BASE + 20] = 16'(prog.size() + 2);
		emit(memInst(slc3Pkg::opLdr, 3'd7, 3'd6, 6'd20));
		emit(aluImm(slc3Pkg::opAdd, 3'd7, 3'd7, 5'd3));
		emit({slc3Pkg::opJmp, 3'b000, 3'd7, 6'd0});
		emit(memInst(slc3Pkg::opStr, 3'd7, 3'd6, 6'd21));
		emit(memInst(slc3Pkg::opStr, 3'd7, 3'd6, 6'd21));
		emit(memInst(slc3Pkg::opStr, 3'd7, 3'd6, 6'd22));
		emit(pauseInst(12'hfff));
		emit(16'hf000);
		runProgram("pause/jump");

		$display("=== PASS ===");
		$finish;
	end

endmodule

//--- test/clockGen.sv
`timescale 1ns/1ps

module clockGen (
	output logic Clk,
	output logic rstN
);

	// 10 ns period
	initial begin
		Clk = 1'b0;
		forever #5 Clk = ~Clk;
	end

	// Low for three rising edges, released just after the third
	initial begin
		rstN = 1'b0;
		repeat (3) @(posedge Clk);
		#1 rstN = 1'b1;
	end

endmodule

//--- src/slc3Top.sv
`timescale 1ns/1ps

module slc3Top #(
	parameter int MEM_AW = 8
) (
	input  logic                         Clk,
	input  logic                         rstN,
	input  logic                         run,
	input  logic                         cont,
	input  logic                         progWe,
	input  logic [MEM_AW-1:0]            progAddr,
	input  logic [slc3Pkg::WORD_W-1:0]   progWdata,
	output logic [slc3Pkg::WORD_W-1:0]   progRdata,
	output logic [11:0]                  LED,
	output logic [slc3Pkg::WORD_W-1:0]   pc,
	output logic [slc3Pkg::WORD_W-1:0]   ir,
	output logic                         halted,
	output logic                         paused
);

	// Controller to datapath
	logic ldMar, ldMdr, ldIr, ldBen, ldCc, ldReg, ldPc, ldLed;
	slc3Pkg::gateT gate;
	slc3Pkg::pcSelT pcSel;
	slc3Pkg::aluOpT aluOp;
	logic drMux, sr1Mux, addr1Mux, mioEn, memWe, ben;
	// Core side of the memory
	logic [slc3Pkg::WORD_W-1:0] memAddr, memWdata, memRdata;

	controlUnit ctrl0 (
		.Clk(Clk), .rstN(rstN), .run(run), .cont(cont), .ir(ir), .ben(ben),
		.ldMar(ldMar), .ldMdr(ldMdr), .ldIr(ldIr), .ldBen(ldBen),
		.ldCc(ldCc), .ldReg(ldReg), .ldPc(ldPc), .ldLed(ldLed),
		.gate(gate), .pcSel(pcSel), .aluOp(aluOp),
		.drMux(drMux), .sr1Mux(sr1Mux), .addr1Mux(addr1Mux),
		.mioEn(mioEn), .memWe(memWe), .halted(halted), .paused(paused)
	);

	datapath dp0 (
		.Clk(Clk), .rstN(rstN),
		.ldMar(ldMar), .ldMdr(ldMdr), .ldIr(ldIr), .ldBen(ldBen),
		.ldCc(ldCc), .ldReg(ldReg), .ldPc(ldPc), .ldLed(ldLed),
		.gate(gate), .pcSel(pcSel), .aluOp(aluOp),
		.drMux(drMux), .sr1Mux(sr1Mux), .addr1Mux(addr1Mux), .mioEn(mioEn),
		.memRdata(memRdata), .memAddr(memAddr), .memWdata(memWdata),
		.ir(ir), .ben(ben), .pc(pc), .led(LED)
	);

	// Only the low MEM_AW bits of MAR reach the memory
	wordMemory #(.MEM_AW(MEM_AW)) mem0 (
		.Clk(Clk), .we(memWe), .addr(memAddr[MEM_AW-1:0]),
		.wdata(memWdata), .rdata(memRdata),
		.progWe(progWe), .progAddr(progAddr),
		.progWdata(progWdata), .progRdata(progRdata)
	);

endmodule

//--- src/wordMemory.sv
`timescale 1ns/1ps

module wordMemory #(
	parameter int MEM_AW = 8
) (
	input  logic                         Clk,
	input  logic                         we,
	input  logic [MEM_AW-1:0]            addr,
	input  logic [slc3Pkg::WORD_W-1:0]   wdata,
	output logic [slc3Pkg::WORD_W-1:0]   rdata,
	input  logic                         progWe,
	input  logic [MEM_AW-1:0]            progAddr,
	input  logic [slc3Pkg::WORD_W-1:0]   progWdata,
	output logic [slc3Pkg::WORD_W-1:0]   progRdata
);

	logic [slc3Pkg::WORD_W-1:0] mem [2**MEM_AW];

	// Core port and program port share one array
	// Reads return the old word on a same-address write
	always_ff @(posedge Clk) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		if (progWe) begin
			mem[progAddr] <= progWdata;
		end
		rdata     <= mem[addr];
		progRdata <= mem[progAddr];
	end

	// Core and loader must not collide on one word
	assert property (@(posedge Clk) !(we && progWe && addr == progAddr));

endmodule

//--- src/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
	input  logic               Clk,
	input  logic               rstN,
	input  logic               run,
	input  logic               cont,
	input  logic [15:0]        ir,
	input  logic               ben,
	output logic               ldMar,
	output logic               ldMdr,
	output logic               ldIr,
	output logic               ldBen,
	output logic               ldCc,
	output logic               ldReg,
	output logic               ldPc,
	output logic               ldLed,
	output slc3Pkg::gateT      gate,
	output slc3Pkg::pcSelT     pcSel,
	output slc3Pkg::aluOpT     aluOp,
	output logic               drMux,
	output logic               sr1Mux,
	output logic               addr1Mux,
	output logic               mioEn,
	output logic               memWe,
	output logic               halted,
	output logic               paused
);

	slc3Pkg::stateT state, stateNext;
	slc3Pkg::opcodeT opcode;
	// High from the second cycle spent in the same state
	logic step;

	assign opcode = slc3Pkg::opcodeT'(ir[15:12]);

	always_ff @(posedge Clk) begin
		if (!rstN) begin
			state <= slc3Pkg::sHalted;
			step  <= 1'b0;
		end else begin
			state <= stateNext;
			step  <= (stateNext == state);
		end
	end

	always_comb begin
		stateNext = state;
		case (state)
			slc3Pkg::sHalted: if (run) stateNext = slc3Pkg::sFetch1;
			slc3Pkg::sFetch1: stateNext = slc3Pkg::sFetch2;
			slc3Pkg::sFetch2: stateNext = slc3Pkg::sFetch3;
			slc3Pkg::sFetch3: stateNext = slc3Pkg::sDecode;
			// First Decode cycle loads IR, the second dispatches on it
			slc3Pkg::sDecode: begin
				if (step) begin
					case (opcode)
						slc3Pkg::opAdd, slc3Pkg::opAnd, slc3Pkg::opNot:
							stateNext = slc3Pkg::sExecAlu;
						slc3Pkg::opBr:    stateNext = slc3Pkg::sBranch;
						slc3Pkg::opJmp:   stateNext = slc3Pkg::sJump;
						slc3Pkg::opLdr, slc3Pkg::opStr:
							stateNext = slc3Pkg::sAddrCalc;
						slc3Pkg::opPause: stateNext = slc3Pkg::sPause1;
						// Unknown opcode stops the core
						default:          stateNext = slc3Pkg::sHalted;
					endcase
				end
			end
			slc3Pkg::sAddrCalc: begin
				stateNext = (opcode == slc3Pkg::opStr) ? slc3Pkg::sWriteMem : slc3Pkg::sReadWait;
			end
			slc3Pkg::sReadWait: stateNext = slc3Pkg::sReadDone;
			slc3Pkg::sReadDone: stateNext = slc3Pkg::sLoadReg;
			// Two cycles, MDR load then the write strobe
			slc3Pkg::sWriteMem: if (step) stateNext = slc3Pkg::sFetch1;
			slc3Pkg::sPause1: if (step && cont) stateNext = slc3Pkg::sPause2;
			slc3Pkg::sExecAlu, slc3Pkg::sBranch, slc3Pkg::sJump,
			slc3Pkg::sLoadReg, slc3Pkg::sPause2: stateNext = slc3Pkg::sFetch1;
			default: stateNext = slc3Pkg::sHalted;
		endcase
	end

	always_comb begin
		ldMar    = 1'b0;
		ldMdr    = 1'b0;
		ldIr     = 1'b0;
		ldBen    = 1'b0;
		ldCc     = 1'b0;
		ldReg    = 1'b0;
		ldPc     = 1'b0;
		ldLed    = 1'b0;
		gate     = slc3Pkg::gateNone;
		pcSel    = slc3Pkg::pcInc;
		aluOp    = slc3Pkg::aluPassA;
		drMux    = 1'b0;
		sr1Mux   = 1'b0;
		addr1Mux = 1'b0;
		mioEn    = 1'b0;
		memWe    = 1'b0;
		halted   = (state == slc3Pkg::sHalted);
		// LED already holds the operand once paused rises
		paused   = (state == slc3Pkg::sPause1) && step;
		case (state)
			slc3Pkg::sHalted: begin
				// Idle bus is zero, so run restarts at address 0
				ldPc  = run;
				pcSel = slc3Pkg::pcBus;
			end
			slc3Pkg::sFetch1: begin
				gate  = slc3Pkg::gatePc;
				ldMar = 1'b1;
				ldPc  = 1'b1;
			end
			slc3Pkg::sFetch3, slc3Pkg::sReadDone: begin
				ldMdr = 1'b1;
				mioEn = 1'b1;
			end
			slc3Pkg::sDecode: begin
				gate  = step ? slc3Pkg::gateNone : slc3Pkg::gateMdr;
				ldIr  = !step;
				ldBen = step;
			end
			slc3Pkg::sExecAlu: begin
				gate   = slc3Pkg::gateAlu;
				sr1Mux = 1'b1;
				ldReg  = 1'b1;
				ldCc   = 1'b1;
				case (opcode)
					slc3Pkg::opAnd: aluOp = slc3Pkg::aluAnd;
					slc3Pkg::opNot: aluOp = slc3Pkg::aluNot;
					default:        aluOp = slc3Pkg::aluAdd;
				endcase
			end
			slc3Pkg::sBranch: begin
				pcSel = slc3Pkg::pcAdder;
				ldPc  = ben;
			end
			// BaseR passes through the ALU onto the bus
			slc3Pkg::sJump: begin
				gate   = slc3Pkg::gateAlu;
				sr1Mux = 1'b1;
				pcSel  = slc3Pkg::pcBus;
				ldPc   = 1'b1;
			end
			slc3Pkg::sAddrCalc: begin
				gate     = slc3Pkg::gateMarMux;
				addr1Mux = 1'b1;
				sr1Mux   = 1'b1;
				ldMar    = 1'b1;
			end
			slc3Pkg::sLoadReg: begin
				gate  = slc3Pkg::gateMdr;
				ldReg = 1'b1;
				ldCc  = 1'b1;
			end
			// Source register from IR[11:9] into MDR, then write
			slc3Pkg::sWriteMem: begin
				gate  = step ? slc3Pkg::gateNone : slc3Pkg::gateAlu;
				ldMdr = !step;
				memWe = step;
			end
			slc3Pkg::sPause1: ldLed = !step;
			default: ;
		endcase
	end

	// Memory is written only from the store state
	assert property (@(posedge Clk) disable iff (!rstN) memWe |-> state == slc3Pkg::sWriteMem);
	assert property (@(posedge Clk) disable iff (!rstN) !(ldReg && memWe));
	// Any reset cycle leaves the core halted
	assert property (@(posedge Clk) !rstN |=> state == slc3Pkg::sHalted);

endmodule

//--- src/datapath.sv
`timescale 1ns/1ps

module datapath (
	input  logic                         Clk,
	input  logic                         rstN,
	input  logic                         ldMar,
	input  logic                         ldMdr,
	input  logic                         ldIr,
	input  logic                         ldBen,
	input  logic                         ldCc,
	input  logic                         ldReg,
	input  logic                         ldPc,
	input  logic                         ldLed,
	input  slc3Pkg::gateT                gate,
	input  slc3Pkg::pcSelT               pcSel,
	input  slc3Pkg::aluOpT               aluOp,
	input  logic                         drMux,
	input  logic                         sr1Mux,
	input  logic                         addr1Mux,
	input  logic                         mioEn,
	input  logic [slc3Pkg::WORD_W-1:0]   memRdata,
	output logic [slc3Pkg::WORD_W-1:0]   memAddr,
	output logic [slc3Pkg::WORD_W-1:0]   memWdata,
	output logic [slc3Pkg::WORD_W-1:0]   ir,
	output logic                         ben,
	output logic [slc3Pkg::WORD_W-1:0]   pc,
	output logic [11:0]                  led
);

	logic [slc3Pkg::WORD_W-1:0] mar, mdr, bus;
	logic [slc3Pkg::WORD_W-1:0] sr1Out, sr2Out, aluB, aluOut;
	logic [slc3Pkg::WORD_W-1:0] addr1, addr2, addrSum;
	logic [2:0] drSel, sr1Sel;
	// Condition codes, n z p from high to low
	logic [2:0] nzp;

	// DRMUX picks R7 for link style writes
	assign drSel = drMux ? 3'b111 : ir[11:9];
	// SR1MUX picks BaseR/SR1 or the STR source field
	assign sr1Sel = sr1Mux ? ir[8:6] : ir[11:9];

	regFile rf0 (
		.Clk(Clk),
		.rstN(rstN),
		.ld(ldReg),
		.dr(drSel),
		.sr1(sr1Sel),
		.sr2(ir[2:0]),
		.din(bus),
		.sr1Out(sr1Out),
		.sr2Out(sr2Out)
	);

	// IR[5] selects the sign-extended imm5 over SR2
	assign aluB = ir[5] ? {{(slc3Pkg::WORD_W-5){ir[4]}}, ir[4:0]} : sr2Out;

	always_comb begin
		case (aluOp)
			slc3Pkg::aluAdd: aluOut = sr1Out + aluB;
			slc3Pkg::aluAnd: aluOut = sr1Out & aluB;
			slc3Pkg::aluNot: aluOut = ~sr1Out;
			default:         aluOut = sr1Out;
		endcase
	end

	// Base plus offset6 for LDR/STR, PC plus offset9 for BR
	assign addr1 = addr1Mux ? sr1Out : pc;
	assign addr2 = addr1Mux ? {{(slc3Pkg::WORD_W-6){ir[5]}}, ir[5:0]}
	                        : {{(slc3Pkg::WORD_W-9){ir[8]}}, ir[8:0]};
	assign addrSum = addr1 + addr2;

	// Internal bus, idles at zero with no gate open
	always_comb begin
		case (gate)
			slc3Pkg::gatePc:     bus = pc;
			slc3Pkg::gateMdr:    bus = mdr;
			slc3Pkg::gateAlu:    bus = aluOut;
			slc3Pkg::gateMarMux: bus = addrSum;
			default:             bus = '0;
		endcase
	end

	always_ff @(posedge Clk) begin
		if (!rstN) begin
			pc  <= '0;
			mar <= '0;
			mdr <= '0;
			ir  <= '0;
			led <= '0;
			ben <= 1'b0;
			// Z after reset
			nzp <= 3'b010;
		end else begin
			if (ldPc) begin
				case (pcSel)
					slc3Pkg::pcBus:   pc <= bus;
					slc3Pkg::pcAdder: pc <= addrSum;
					default:          pc <= pc + 1'b1;
				endcase
			end
			if (ldMar) begin
				mar <= bus;
			end
			// Memory side or bus side into MDR
			if (ldMdr) begin
				mdr <= mioEn ? memRdata : bus;
			end
			if (ldIr) begin
				ir <= bus;
			end
			if (ldCc) begin
				nzp <= {bus[slc3Pkg::WORD_W-1], bus == '0, !bus[slc3Pkg::WORD_W-1] && bus != '0};
			end
			// Branch enable from the nzp mask in IR[11:9]
			if (ldBen) begin
				ben <= |(ir[11:9] & nzp);
			end
			// PAUSE operand straight from IR
			if (ldLed) begin
				led <= ir[11:0];
			end
		end
	end

	assign memAddr  = mar;
	assign memWdata = mdr;

	// A fresh IR must not coincide with a PC change from the controller
	assert property (@(posedge Clk) disable iff (!rstN) $rose(ldIr) |-> !ldPc);

endmodule

//--- src/regFile.sv
`timescale 1ns/1ps

module regFile (
	input  logic                         Clk,
	input  logic                         rstN,
	input  logic                         ld,
	input  logic [2:0]                   dr,
	input  logic [2:0]                   sr1,
	input  logic [2:0]                   sr2,
	input  logic [slc3Pkg::WORD_W-1:0]   din,
	output logic [slc3Pkg::WORD_W-1:0]   sr1Out,
	output logic [slc3Pkg::WORD_W-1:0]   sr2Out
);

	// R0 to R7
	logic [slc3Pkg::WORD_W-1:0] regs [8];

	// Single write port, loads the bus value into DR
	always_ff @(posedge Clk) begin
		if (!rstN) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (ld) begin
			regs[dr] <= din;
		end
	end

	// Both source reads are combinational
	// so ALU and address adder see the operands in the same cycle
	assign sr1Out = regs[sr1];
	assign sr2Out = regs[sr2];

endmodule

//--- src/slc3Pkg.sv
package slc3Pkg;

	// Width of every data word, register and bus
	localparam int WORD_W = 16;

	// Instruction opcodes as found in IR[15:12]
	typedef enum logic [3:0] {
		opBr    = 4'd0,
		opAdd   = 4'd1,
		opAnd   = 4'd5,
		opLdr   = 4'd6,
		opStr   = 4'd7,
		opNot   = 4'd9,
		opJmp   = 4'd12,
		opPause = 4'd13
	} opcodeT;

	// Controller states
	typedef enum logic [3:0] {
		sHalted,
		sFetch1,
		sFetch2,
		sFetch3,
		sDecode,
		sExecAlu,
		sBranch,
		sJump,
		sAddrCalc,
		sReadWait,
		sReadDone,
		sLoadReg,
		sWriteMem,
		sPause1,
		sPause2
	} stateT;

	// ALU function select
	typedef enum logic [1:0] {
		aluAdd,
		aluAnd,
		aluNot,
		aluPassA
	} aluOpT;

	// Single driver of the internal bus
	typedef enum logic [2:0] {
		gateNone,
		gatePc,
		gateMdr,
		gateAlu,
		gateMarMux
	} gateT;

	// Source of the next PC value
	typedef enum logic [1:0] {
		pcInc,
		pcBus,
		pcAdder
	} pcSelT;

endpackage
